/* subway.sv */
`timescale 1ns/10ps
`default_nettype none

`include "subway_cfg.svh"

module subway (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [`SUBWAY_LANE_W-1:0]    init,
    input  subway_pkg::cell_t            in0,
    input  subway_pkg::cell_t            in1,
    input  subway_pkg::cell_t            in2,
    input  subway_pkg::cell_t            in3,
    output logic                         out_valid,
    output subway_pkg::action_t          out
);

    // sequencing
    logic load_en;
    logic plan_start;
    logic plan_done;
    logic emit_start;
    logic emit_done;

    // store read ports
    logic [`SUBWAY_FRAME_W-1:0] rd_a_frame;
    logic [`SUBWAY_ROW_W-1:0]   rd_a_row;
    logic [`SUBWAY_FRAME_W-1:0] rd_b_frame;
    logic [`SUBWAY_ROW_W-1:0]   rd_b_row;

    logic [`SUBWAY_LANE_W-1:0]                   start_lane;
    logic [`SUBWAY_SEGMENTS*`SUBWAY_LANE_W-1:0]  seg_target; // flattened, seg 0 in low bits

    subway_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .plan_done  (plan_done),
        .emit_done  (emit_done),
        .load_en    (load_en),
        .plan_start (plan_start),
        .emit_start (emit_start)
    );

    subway_map_store u_map_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .in0        (in0),
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .init       (init),
        .rd_a_frame (rd_a_frame),
        .rd_b_frame (rd_b_frame),
        .rd_a_row   (rd_a_row),
        .rd_b_row   (rd_b_row),
        .start_lane (start_lane)
    );

    subway_route_planner u_route_planner (
        .clk        (clk),
        .rst_n      (rst_n),
        .plan_start (plan_start),
        .rd_a_row   (rd_a_row),
        .rd_a_frame (rd_a_frame),
        .plan_done  (plan_done),
        .seg_target (seg_target)
    );

    subway_action_stream u_action_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .emit_start (emit_start),
        .start_lane (start_lane),
        .seg_target (seg_target),
        .rd_b_row   (rd_b_row),
        .rd_b_frame (rd_b_frame),
        .emit_done  (emit_done),
        .out_valid  (out_valid),
        .out        (out)
    );

endmodule

`default_nettype wire

/* subway_action_stream.sv */
`timescale 1ns/10ps
`default_nettype none

`include "subway_cfg.svh"

module subway_action_stream (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          emit_start,
    input  logic [`SUBWAY_LANE_W-1:0]                     start_lane,
    input  logic [`SUBWAY_SEGMENTS*`SUBWAY_LANE_W-1:0]    seg_target,
    input  logic [`SUBWAY_ROW_W-1:0]                      rd_b_row,
    output logic [`SUBWAY_FRAME_W-1:0]                    rd_b_frame,
    output logic                                          emit_done,
    output logic                                          out_valid,
    output subway_pkg::action_t                           out
);

    logic                                   active;
    logic                                   running;
    logic [`SUBWAY_FRAME_W-1:0]             step_q;
    logic [`SUBWAY_LANE_W-1:0]              lane_q;
    logic [`SUBWAY_LANE_W-1:0]              cur_lane;
    logic [`SUBWAY_LANE_W-1:0]              target;
    logic [`SUBWAY_LANE_W-1:0]              next_lane;
    logic [$clog2(`SUBWAY_SEGMENTS)-1:0]    seg_idx;
    subway_pkg::action_t                    action;

    // step 0 is worked out in the emit_start cycle itself
    assign running  = emit_start | active;
    assign cur_lane = emit_start ? start_lane : lane_q;

    assign seg_idx    = step_q[`SUBWAY_FRAME_W-1:$clog2(`SUBWAY_TRAIN_GAP)];
    assign rd_b_frame = step_q + 1'b1; // frame being entered

    assign emit_done = running && (step_q == `SUBWAY_STEPS - 1);

    always_comb begin
        target = cur_lane; // last segment has no train row ahead
        if (seg_idx < `SUBWAY_SEGMENTS) begin
            target = seg_target[seg_idx*`SUBWAY_LANE_W +: `SUBWAY_LANE_W];
        end
    end

    always_comb begin
        next_lane = cur_lane;
        if (step_q[0] && target > cur_lane) begin
            action    = subway_pkg::act_right;
            next_lane = cur_lane + 1'b1;
        end else if (step_q[0] && target < cur_lane) begin
            action    = subway_pkg::act_left;
            next_lane = cur_lane - 1'b1;
        end else if (rd_b_row[cur_lane*`SUBWAY_CELL_W +: `SUBWAY_CELL_W] ==
                     subway_pkg::low_obstacle) begin
            action = subway_pkg::act_jump;
        end else begin
            action = subway_pkg::act_forward; // road and high obstacles alike
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            step_q <= '0;
            lane_q <= '0;
        end else if (running) begin
            lane_q <= next_lane;
            if (emit_done) begin
                active <= 1'b0;
                step_q <= '0;
            end else begin
                active <= 1'b1;
                step_q <= step_q + 1'b1;
            end
        end
    end

    // registered output, one action per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= subway_pkg::act_forward;
        end else begin
            out_valid <= running;
            out       <= running ? action : subway_pkg::act_forward;
        end
    end

endmodule

`default_nettype wire

/* subway_cfg.svh */
`ifndef SUBWAY_CFG_SVH
`define SUBWAY_CFG_SVH

// map format
`define SUBWAY_FRAMES     64
`define SUBWAY_LANES      4
`define SUBWAY_LANE_W     2
`define SUBWAY_CELL_W     2
`define SUBWAY_ROW_W      (`SUBWAY_LANES * `SUBWAY_CELL_W)
`define SUBWAY_FRAME_W    6

// train rows every 8 frames, starting at frame 8
`define SUBWAY_TRAIN_GAP  8
`define SUBWAY_SEGMENTS   7

// one action per frame transition
`define SUBWAY_STEPS      63

`endif

/* subway_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module subway_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic plan_done,
    input  logic emit_done,
    output logic load_en,
    output logic plan_start,
    output logic emit_start
);

    subway_pkg::ctrl_state_t state;
    subway_pkg::ctrl_state_t state_nx;

    always_comb begin
        state_nx = state;
        case (state)
            subway_pkg::st_idle: begin
                if (in_valid) begin
                    state_nx = subway_pkg::st_load;
                end
            end
            subway_pkg::st_load: begin
                if (!in_valid) begin
                    state_nx = subway_pkg::st_plan;
                end
            end
            subway_pkg::st_plan: begin
                if (plan_done) begin
                    state_nx = subway_pkg::st_emit;
                end
            end
            subway_pkg::st_emit: begin
                if (emit_done) begin
                    state_nx = subway_pkg::st_idle;
                end
            end
            default: begin
                state_nx = subway_pkg::st_idle;
            end
        endcase
    end

    // frame 0 arrives while still in idle
    assign load_en = in_valid &&
                     (state == subway_pkg::st_idle || state == subway_pkg::st_load);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= subway_pkg::st_idle;
            plan_start <= 1'b0;
            emit_start <= 1'b0;
        end else begin
            state      <= state_nx;
            // pulses on state entry
            plan_start <= (state == subway_pkg::st_load) && !in_valid;
            emit_start <= (state == subway_pkg::st_plan) && plan_done;
        end
    end

endmodule

`default_nettype wire

/* subway_map_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "subway_cfg.svh"

module subway_map_store (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_en,
    input  subway_pkg::cell_t            in0,
    input  subway_pkg::cell_t            in1,
    input  subway_pkg::cell_t            in2,
    input  subway_pkg::cell_t            in3,
    input  logic [`SUBWAY_LANE_W-1:0]    init,
    input  logic [`SUBWAY_FRAME_W-1:0]   rd_a_frame,
    input  logic [`SUBWAY_FRAME_W-1:0]   rd_b_frame,
    output logic [`SUBWAY_ROW_W-1:0]     rd_a_row,
    output logic [`SUBWAY_ROW_W-1:0]     rd_b_row,
    output logic [`SUBWAY_LANE_W-1:0]    start_lane
);

    // lane l sits at bits [2l+1:2l] of a row
    logic [`SUBWAY_ROW_W-1:0]   mem [0:`SUBWAY_FRAMES-1];
    logic [`SUBWAY_FRAME_W-1:0] wr_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (load_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end else begin
            wr_ptr <= '0; // ready for next map
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_lane <= '0;
        end else if (load_en && wr_ptr == '0) begin
            start_lane <= init; // sampled with frame 0 only
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_ptr] <= {in3, in2, in1, in0};
        end
    end

    // planner port
    assign rd_a_row = mem[rd_a_frame];
    // emitter port
    assign rd_b_row = mem[rd_b_frame];

endmodule

`default_nettype wire

/* subway_pkg.sv */
`default_nettype none

`include "subway_cfg.svh"

package subway_pkg;

    typedef enum logic [`SUBWAY_CELL_W-1:0] {
        road          = 2'd0,
        low_obstacle  = 2'd1, // needs a jump
        high_obstacle = 2'd2, // passed going forward
        train         = 2'd3
    } cell_t;

    typedef enum logic [1:0] {
        act_forward = 2'd0,
        act_right   = 2'd1, // toward higher lane index
        act_left    = 2'd2,
        act_jump    = 2'd3
    } action_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_load = 2'd1,
        st_plan = 2'd2,
        st_emit = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

/* subway_route_planner.sv */
`timescale 1ns/10ps
`default_nettype none

`include "subway_cfg.svh"

module subway_route_planner (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          plan_start,
    input  logic [`SUBWAY_ROW_W-1:0]                      rd_a_row,
    output logic [`SUBWAY_FRAME_W-1:0]                    rd_a_frame,
    output logic                                          plan_done,
    output logic [`SUBWAY_SEGMENTS*`SUBWAY_LANE_W-1:0]    seg_target
);

    logic                                   busy;
    logic [$clog2(`SUBWAY_SEGMENTS)-1:0]    seg_q;
    logic [`SUBWAY_LANE_W-1:0]              free_lane;

    // train row of segment s is frame 8*(s+1)
    assign rd_a_frame = {seg_q + 1'b1, {$clog2(`SUBWAY_TRAIN_GAP){1'b0}}};

    // lowest lane without a train wins
    always_comb begin
        free_lane = '0;
        for (int l = `SUBWAY_LANES - 1; l >= 0; l--) begin
            if (rd_a_row[l*`SUBWAY_CELL_W +: `SUBWAY_CELL_W] != subway_pkg::train) begin
                free_lane = l[`SUBWAY_LANE_W-1:0];
            end
        end
    end

    assign plan_done = busy && (seg_q == `SUBWAY_SEGMENTS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            seg_q <= '0;
        end else if (plan_start) begin
            busy  <= 1'b1;
            seg_q <= '0;
        end else if (busy) begin
            if (plan_done) begin
                busy  <= 1'b0;
                seg_q <= '0;
            end else begin
                seg_q <= seg_q + 1'b1;
            end
        end
    end

    // one target per train row
    always_ff @(posedge clk) begin
        if (busy) begin
            seg_target[seg_q*`SUBWAY_LANE_W +: `SUBWAY_LANE_W] <= free_lane;
        end
    end

endmodule

`default_nettype wire

/* tb_subway.sv */
`timescale 1ns/10ps
`default_nettype none

`include "subway_cfg.svh"

module tb_subway;

    localparam integer N_MAPS     = 4;
    localparam integer MAP_CYCLES = 160; // 64 load + 73 out window + slack
    localparam integer TIMEOUT_NS = (N_MAPS * MAP_CYCLES + 100) * 8;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [`SUBWAY_LANE_W-1:0] init;
    subway_pkg::cell_t         in0;
    subway_pkg::cell_t         in1;
    subway_pkg::cell_t         in2;
    subway_pkg::cell_t         in3;
    logic                      out_valid;
    subway_pkg::action_t       out;

    // reference map and expected route
    logic [1:0] map_c     [0:`SUBWAY_FRAMES-1][0:`SUBWAY_LANES-1];
    logic       is_land   [0:`SUBWAY_FRAMES-1][0:`SUBWAY_LANES-1];
    logic [1:0] free_lane [0:`SUBWAY_SEGMENTS-1];
    logic [1:0] ref_lane  [0:`SUBWAY_FRAMES-1];
    logic [1:0] exp_act   [0:`SUBWAY_STEPS-1];

    integer     seed = 32'h49146825;
    integer     err_cnt = 0;
    integer     tests_pass = 0;
    integer     tests_fail = 0;
    integer     maps_done = 0;
    logic [1:0] cur_init = 2'd0;

    // checker state
    logic       armed = 1'b0;
    logic       prev_iv = 1'b0;
    integer     rel = 0;
    integer     step = 0;
    integer     err_at_arm = 0;
    logic [1:0] dut_lane = 2'd0;

    subway u_subway (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .init      (init),
        .in0       (in0),
        .in1       (in1),
        .in2       (in2),
        .in3       (in3),
        .out_valid (out_valid),
        .out       (out)
    );

    always #4 clk = ~clk;

    task automatic log_mismatch(input string sig, input integer exp_v, input integer act_v);
        $display("MISMATCH at %0t: %s expected %0d got %0d", $time, sig, exp_v, act_v);
        err_cnt = err_cnt + 1;
    endtask

    // random legal map for one start lane, then the reference actions
    task automatic build_map(input logic [1:0] start);
        integer     f;
        integer     l;
        integer     r;
        integer     seg;
        logic [1:0] lane;
        logic [1:0] tgt;
        for (seg = 0; seg < `SUBWAY_SEGMENTS; seg++) begin
            r = $random(seed);
            free_lane[seg] = r[1:0];
        end
        for (f = 0; f < `SUBWAY_FRAMES; f++) begin
            for (l = 0; l < `SUBWAY_LANES; l++) begin
                is_land[f][l] = 1'b0;
            end
        end
        // lane path only depends on the targets
        ref_lane[0] = start;
        for (f = 0; f < `SUBWAY_STEPS; f++) begin
            seg  = f / `SUBWAY_TRAIN_GAP;
            lane = ref_lane[f];
            tgt  = (seg < `SUBWAY_SEGMENTS) ? free_lane[seg] : lane;
            if ((f % 2) == 1 && lane != tgt) begin
                lane = (lane < tgt) ? lane + 2'd1 : lane - 2'd1;
                is_land[f+1][lane] = 1'b1;
            end
            ref_lane[f+1] = lane;
        end
        for (f = 0; f < `SUBWAY_FRAMES; f++) begin
            for (l = 0; l < `SUBWAY_LANES; l++) begin
                r = $random(seed);
                if (f > 0 && (f % `SUBWAY_TRAIN_GAP) == 0) begin
                    map_c[f][l] = (l == free_lane[f/`SUBWAY_TRAIN_GAP - 1]) ?
                                  subway_pkg::road : subway_pkg::train;
                end else if (f > 0 && (f % 2) == 0) begin
                    case (r[1:0])
                        2'd1:    map_c[f][l] = is_land[f][l] ? subway_pkg::road
                                                             : subway_pkg::low_obstacle;
                        2'd2:    map_c[f][l] = subway_pkg::high_obstacle;
                        default: map_c[f][l] = subway_pkg::road;
                    endcase
                end else begin
                    map_c[f][l] = r[0] ? subway_pkg::high_obstacle : subway_pkg::road;
                end
            end
        end
        for (f = 0; f < `SUBWAY_STEPS; f++) begin
            lane = ref_lane[f];
            if (ref_lane[f+1] > lane) begin
                exp_act[f] = subway_pkg::act_right;
            end else if (ref_lane[f+1] < lane) begin
                exp_act[f] = subway_pkg::act_left;
            end else if (map_c[f+1][lane] == subway_pkg::low_obstacle) begin
                exp_act[f] = subway_pkg::act_jump;
            end else begin
                exp_act[f] = subway_pkg::act_forward;
            end
        end
    endtask

    task automatic load_map(input logic [1:0] start);
        integer k;
        @(posedge clk);
        for (k = 0; k < `SUBWAY_FRAMES; k++) begin
            in_valid <= 1'b1;
            init     <= (k == 0) ? start : ~start; // only frame 0 counts
            in0      <= subway_pkg::cell_t'(map_c[k][0]);
            in1      <= subway_pkg::cell_t'(map_c[k][1]);
            in2      <= subway_pkg::cell_t'(map_c[k][2]);
            in3      <= subway_pkg::cell_t'(map_c[k][3]);
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // stray in_valid while the DUT is emitting
    task automatic pulse_in_valid_during_emit();
        repeat (40) @(posedge clk);
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // rel 0 is the first cycle with in_valid low
    always @(negedge clk) begin
        if (!rst_n) begin
            armed   = 1'b0;
            prev_iv = 1'b0;
        end else begin
            if (!armed && prev_iv && !in_valid) begin
                armed      = 1'b1;
                rel        = 0;
                dut_lane   = cur_init;
                err_at_arm = err_cnt;
            end else if (armed) begin
                rel = rel + 1;
            end
            prev_iv = in_valid;
            if (armed && rel >= 10 && rel <= 72) begin
                step = rel - 10;
                assert (out_valid === 1'b1) else log_mismatch("out_valid", 1, out_valid);
                assert (out === exp_act[step]) else log_mismatch("out", exp_act[step], out);
                if (step >= 56) begin
                    assert (out == subway_pkg::act_forward || out == subway_pkg::act_jump)
                        else log_mismatch("out (last segment)", 0, out);
                end
                if (out == subway_pkg::act_right) begin
                    dut_lane = dut_lane + 2'd1;
                end else if (out == subway_pkg::act_left) begin
                    dut_lane = dut_lane - 2'd1;
                end
                if ((step % 8) == 7 && step < 56) begin
                    assert (dut_lane == free_lane[step/8])
                        else log_mismatch("lane at train frame", free_lane[step/8], dut_lane);
                end
            end else begin
                assert (out_valid === 1'b0) else log_mismatch("out_valid", 0, out_valid);
            end
            if (armed && rel == 75) begin
                armed = 1'b0;
                if (err_cnt == err_at_arm) begin
                    tests_pass = tests_pass + 1;
                    $display("map %0d (init %0d): ok", maps_done, cur_init);
                end else begin
                    tests_fail = tests_fail + 1;
                    $display("map %0d (init %0d): %0d errors", maps_done, cur_init,
                             err_cnt - err_at_arm);
                end
                maps_done = maps_done + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: DUT did not finish all maps in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        integer     m;
        integer     err_before;
        logic [1:0] start;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        init     = '0;
        in0      = subway_pkg::road;
        in1      = subway_pkg::road;
        in2      = subway_pkg::road;
        in3      = subway_pkg::road;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // nothing loaded yet
        err_before = err_cnt;
        repeat (20) @(posedge clk);
        if (err_cnt == err_before) begin
            tests_pass = tests_pass + 1;
            $display("idle after reset: ok");
        end else begin
            tests_fail = tests_fail + 1;
            $display("idle after reset: %0d errors", err_cnt - err_before);
        end

        for (m = 0; m < N_MAPS; m++) begin
            start = (m * 3) % 4;
            build_map(start);
            cur_init = start;
            load_map(start);
            if (m == 2) begin
                pulse_in_valid_during_emit();
            end
            while (maps_done < m + 1) begin
                @(posedge clk);
            end
            repeat (3) @(posedge clk);
        end

        $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
        if (tests_fail == 0 && err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
subway_pkg.sv
subway_ctrl.sv
subway_map_store.sv
subway_route_planner.sv
subway_action_stream.sv
subway.sv
tb_subway.sv
